//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
TOP       := camConfigTb
FILELIST  := all.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
+incdir+.
camConfigPkg.sv
cameraConfigRom.sv
configSequencer.sv
sccbWriter.sv
configStatus.sv
camConfigTop.sv
camConfigTb.sv

//--- camConfigPkg.sv
// Types only; writeCount shares the ROM index width, so tables longer than 63 writes wrap it
`default_nettype none

`include "camConfig_config.svh"

package camConfigPkg;

  // Classification of one table entry
  typedef enum logic [1:0]
  {
    cmdWrite     = 2'd0,
    cmdWriteWait = 2'd1,
    cmdFinish    = 2'd2
  } cmdKind;

  // Sequencer states
  typedef enum logic [2:0]
  {
    seqIdle,
    seqFetch,
    seqDecode,
    seqIssue,
    seqWait,
    seqDone
  } seqState;

  // SCCB writer phases
  typedef enum logic [2:0]
  {
    phIdle,
    phStart,
    phShift,
    phStop,
    phGap
  } sccbPhase;

  // One register write as handed to the bus writer
  typedef struct packed
  {
    logic [7:0] addr;
    logic [7:0] value;
    logic       waitAfter;
  } sccbCmd;

  // Progress report
  typedef struct packed
  {
    logic                   busy;
    logic                   done;
    logic [`CAM_ROM_AW-1:0] writeCount;
  } cfgStatus;

endpackage

`default_nettype wire

//--- camConfigTb.sv
// Runs from the project root so configInput.hex is found; the cycle limit assumes the simulation timing
`timescale 1ns/1ps
`default_nettype none

`include "camConfig_config.svh"

module camConfigTb;

  import camConfigPkg::*;

  // Lengths of one SCCB bit and one full write in clk cycles
  localparam int BitCycles  = 4 * `CAM_SCCB_QUARTER;
  localparam int TxnCycles  = BitCycles * 29;
  // Write plus trailing gap and fetch overhead
  localparam int SlotCycles = TxnCycles + BitCycles + 8;
  localparam int IdleCheck  = 8 * BitCycles;

  logic     clk;
  logic     rst;
  logic     start;
  logic     startReady;
  logic     sioc;
  logic     siodOut;
  logic     siodOe;
  logic     siodLine;
  cfgStatus status;

  logic [15:0] expMem [0:63];
  int          expCount;
  int          errCount    = 0;
  int          checkCount  = 0;
  int          testErrBase = 0;
  int          testsRun    = 0;
  int          testsPassed = 0;
  int          cycleCount  = 0;
  int          cycleLimit  = 0;
  logic [31:0] rngState    = 32'hc687f5d8;

  // Bus monitor state
  logic        prevSioc     = 1'b1;
  logic        prevLine     = 1'b1;
  logic        inFrame      = 1'b0;
  logic        gapValid     = 1'b0;
  logic        prevWasReset = 1'b0;
  int          bitCount     = 0;
  int          idleCycles   = 0;
  int          writeIdx     = 0;
  logic [26:0] frameBits    = '0;

  // Released pin reads high through the board pull-up
  assign siodLine = siodOe ? siodOut : 1'b1;

  camConfigTop dut
    (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .startReady (startReady),
      .sioc       (sioc),
      .siodOut    (siodOut),
      .siodOe     (siodOe),
      .status     (status)
    );

  initial
  begin
    clk = 1'b0;
    forever
      #10 clk = ~clk;
  end

  function automatic logic [31:0] nextRandom(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic noteError(input string msg);
    errCount++;
    $display("t=%0t %s", $time, msg);
  endtask

  task automatic checkLevel(input string name, input logic expVal, input logic gotVal);
    checkCount++;
    if (gotVal !== expVal)
    begin
      errCount++;
      $display("[FAIL] t=%0t %s: expected %b, got %b", $time, name, expVal, gotVal);
    end
  endtask

  task automatic checkByte(input string name, input logic [7:0] expVal,
                           input logic [7:0] gotVal);
    checkCount++;
    if (gotVal !== expVal)
    begin
      errCount++;
      $display("[FAIL] t=%0t %s: expected %h, got %h", $time, name, expVal, gotVal);
    end
  endtask

  // Only address and value are visible on the bus
  task automatic checkCmd(input int idx, input sccbCmd expVal, input sccbCmd gotVal);
    checkCount++;
    if ((gotVal.addr !== expVal.addr) || (gotVal.value !== expVal.value))
    begin
      errCount++;
      $display("[FAIL] t=%0t siod write %0d addr/value: expected %h/%h, got %h/%h",
               $time, idx, expVal.addr, expVal.value, gotVal.addr, gotVal.value);
    end
  endtask

  task automatic checkStatus(input string name, input cfgStatus expVal,
                             input cfgStatus gotVal);
    checkCount++;
    if (gotVal !== expVal)
    begin
      errCount++;
      $display(
        "[FAIL] t=%0t %s: expected busy=%b done=%b count=%0d, got busy=%b done=%b count=%0d",
        $time, name, expVal.busy, expVal.done, expVal.writeCount,
        gotVal.busy, gotVal.done, gotVal.writeCount);
    end
  endtask

  task automatic beginTest();
    testErrBase = errCount;
    testsRun++;
  endtask

  task automatic reportTest(input string name);
    if (errCount == testErrBase)
    begin
      testsPassed++;
      $display("test %s: ok", name);
    end
    else
      $display("test %s: %0d errors", name, errCount - testErrBase);
  endtask

  // Start condition checks the idle time since the last stop
  task automatic startFrame();
    if (inFrame)
      noteError("start condition inside a frame");
    if (gapValid)
    begin
      if (prevWasReset && (idleCycles < `CAM_RESET_WAIT))
        noteError($sformatf("only %0d idle cycles after the soft-reset write", idleCycles));
      else if (!prevWasReset && (idleCycles >= `CAM_RESET_WAIT))
        noteError($sformatf("%0d idle cycles before write %0d, reset wait not expected",
                            idleCycles, writeIdx));
    end
    inFrame   = 1'b1;
    bitCount  = 0;
    frameBits = '0;
  endtask

  // Pulses 0 to 26 carry data and pulse 27 is the stop setup clock
  task automatic sampleBit();
    if (!inFrame)
      noteError("SIOC pulse outside a start/stop frame");
    else if (bitCount < 27)
    begin
      frameBits = {frameBits[25:0], siodLine};
      checkLevel($sformatf("siodOe bit %0d of write %0d", bitCount, writeIdx),
                 (bitCount % 9) != 8, siodOe);
      bitCount++;
    end
    else if (bitCount == 27)
    begin
      checkLevel("siod low before stop", 1'b0, siodLine);
      bitCount++;
    end
    else
      noteError("extra SIOC pulses after the last data bit");
  endtask

  // Stop condition decodes the ID, address and value
  task automatic closeFrame();
    sccbCmd expCmd;
    sccbCmd gotCmd;
    if (!inFrame || (bitCount != 28))
      noteError($sformatf("stop condition after %0d clock pulses", bitCount));
    else if (writeIdx >= expCount)
      noteError("bus write beyond the end of the table");
    else
    begin
      expCmd.addr      = expMem[writeIdx + 1][15:8];
      expCmd.value     = expMem[writeIdx + 1][7:0];
      // Soft reset is COM7 with bit 7 set
      expCmd.waitAfter = (expCmd.addr == 8'h12) && expCmd.value[7];
      gotCmd.addr      = frameBits[17:10];
      gotCmd.value     = frameBits[8:1];
      gotCmd.waitAfter = 1'b0;
      checkByte($sformatf("device ID of write %0d", writeIdx), `CAM_SCCB_ID, frameBits[26:19]);
      checkLevel("ninth bit after ID", 1'b1, frameBits[18]);
      checkLevel("ninth bit after address", 1'b1, frameBits[9]);
      checkLevel("ninth bit after value", 1'b1, frameBits[0]);
      checkCmd(writeIdx, expCmd, gotCmd);
      prevWasReset = expCmd.waitAfter;
      writeIdx++;
    end
    inFrame    = 1'b0;
    gapValid   = 1'b1;
    idleCycles = 0;
  endtask

  // Bus monitor samples on the falling edge where DUT pins are settled
  always @(negedge clk)
  begin
    if (rst)
    begin
      prevSioc = 1'b1;
      prevLine = 1'b1;
      inFrame  = 1'b0;
    end
    else
    begin
      // SIOD must hold still across every SIOC edge
      if ((sioc != prevSioc) && (siodLine != prevLine))
        noteError("SIOD changed in the same cycle as an SIOC edge");
      // SIOD moving with SIOC high is a start or a stop
      if (sioc && prevSioc && (siodLine != prevLine))
      begin
        if (!siodLine)
          startFrame();
        else
          closeFrame();
      end
      else if (sioc && !prevSioc)
        sampleBit();
      if (!inFrame)
        idleCycles++;
      prevSioc = sioc;
      prevLine = siodLine;
    end
  end

  always @(posedge clk)
  begin
    cycleCount++;
    if ((cycleLimit > 0) && (cycleCount >= cycleLimit))
    begin
      $display("Timeout: run still going after %0d clock cycles", cycleCount);
      $display("TB FAILED");
      $finish;
    end
  end

  // One full pass over the table
  task automatic runTable(input int runNo);
    cfgStatus expSt;
    int       delay;
    string    tag;
    logic     quiet;
    tag = $sformatf("run %0d", runNo);
    beginTest();
    rngState = nextRandom(rngState);
    delay    = int'(rngState[2:0]) + 1;
    repeat (delay) @(negedge clk);
    checkLevel({tag, " startReady before start"}, 1'b1, startReady);
    writeIdx = 0;
    gapValid = 1'b0;
    start    = 1'b1;
    @(negedge clk);
    start = 1'b0;
    checkLevel({tag, " startReady after start"}, 1'b0, startReady);
    @(negedge clk);
    expSt.busy       = 1'b1;
    expSt.done       = 1'b0;
    expSt.writeCount = '0;
    checkStatus({tag, " status after start"}, expSt, status);
    reportTest({tag, " start handshake"});

    beginTest();
    while (status.done !== 1'b1)
      @(negedge clk);
    expSt.busy       = 1'b0;
    expSt.done       = 1'b1;
    expSt.writeCount = expCount[`CAM_ROM_AW-1:0];
    checkStatus({tag, " status at done"}, expSt, status);
    if (writeIdx != expCount)
      noteError($sformatf("%s saw %0d bus writes, the file lists %0d",
                          tag, writeIdx, expCount));
    reportTest({tag, " writes and completion"});

    beginTest();
    quiet = 1'b1;
    for (int i = 0; i < IdleCheck; i++)
    begin
      @(negedge clk);
      if (quiet && ((sioc !== 1'b1) || (siodLine !== 1'b1) || (status.done !== 1'b1)))
      begin
        quiet = 1'b0;
        noteError({tag, ": bus left idle or done dropped after completion"});
      end
    end
    reportTest({tag, " bus idle after done"});
  endtask

  initial
  begin
    rst   = 1'b1;
    start = 1'b0;
    $readmemh("configInput.hex", expMem);
    expCount = int'(expMem[0]);
    if ($isunknown(expMem[0]) || (expCount == 0) || (expCount > 63))
    begin
      $display("Data file configInput.hex holds no usable write count");
      $display("TB FAILED");
      $finish;
    end
    else
    begin
      cycleLimit = 2 * (expCount * SlotCycles + `CAM_RESET_WAIT + IdleCheck + 100) + 50;
      // Reset spans five rising edges
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);

      beginTest();
      checkLevel("sioc after reset", 1'b1, sioc);
      checkLevel("siodOut after reset", 1'b1, siodOut);
      checkLevel("siodOe after reset", 1'b1, siodOe);
      checkLevel("startReady after reset", 1'b1, startReady);
      checkStatus("status after reset", '0, status);
      reportTest("reset state");

      runTable(1);
      // Second start from done repeats the table
      runTable(2);

      $display("tests %0d, passed %0d, checks %0d, errors %0d",
               testsRun, testsPassed, checkCount, errCount);
      if (errCount == 0)
        $display("TB PASSED");
      else
        $display("TB FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- camConfigTop.sv
// SIOD is split into level and enable; the open-drain pad lives in the board wrapper
`timescale 1ns/1ps
`default_nettype none

`include "camConfig_config.svh"

module camConfigTop
  (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              start,
    output logic                   startReady,
    output logic                   sioc,
    output logic                   siodOut,
    output logic                   siodOe,
    output camConfigPkg::cfgStatus status
  );

  import camConfigPkg::*;

  logic [`CAM_ROM_AW-1:0] romIndex;
  logic [15:0]            romWord;
  sccbCmd                 cmd;
  logic                   cmdValid;
  logic                   cmdReady;
  logic                   writeDone;
  logic                   runStart;
  logic                   finished;

  // Register table
  cameraConfigRom romInst
    (
      .clk      (clk),
      .romIndex (romIndex),
      .romWord  (romWord)
    );

  // Decode stage
  configSequencer seqInst
    (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .startReady (startReady),
      .romIndex   (romIndex),
      .romWord    (romWord),
      .cmd        (cmd),
      .cmdValid   (cmdValid),
      .cmdReady   (cmdReady),
      .writeDone  (writeDone),
      .runStart   (runStart),
      .finished   (finished)
    );

  // Bus stage
  sccbWriter writerInst
    (
      .clk       (clk),
      .rst       (rst),
      .cmd       (cmd),
      .cmdValid  (cmdValid),
      .cmdReady  (cmdReady),
      .writeDone (writeDone),
      .sioc      (sioc),
      .siodOut   (siodOut),
      .siodOe    (siodOe)
    );

  // Progress report
  configStatus statusInst
    (
      .clk       (clk),
      .rst       (rst),
      .runStart  (runStart),
      .finished  (finished),
      .writeDone (writeDone),
      .status    (status)
    );

endmodule

`default_nettype wire

//--- camConfig_config.svh
// Timing values suit simulation only; scale CAM_SCCB_QUARTER and CAM_RESET_WAIT (>= 2) to clk
`ifndef CAM_CONFIG_SVH
`define CAM_CONFIG_SVH

// SCCB write address of the OV7670 (7-bit ID 0x21 plus write bit)
`define CAM_SCCB_ID 8'h42

// clk cycles per quarter of one SCCB bit period
// Four quarters make one bit, so SIOC runs at clk / (4 * quarter)
`define CAM_SCCB_QUARTER 4

// Idle cycles after the COM7 soft reset before the next register write
`define CAM_RESET_WAIT 64

// Width of the register table index
// 57 entries plus the end marker fit in 64 slots
`define CAM_ROM_AW 6

`endif

//--- cameraConfigRom.sv
// Case items assume a 6-bit index; every slot from 0x39 upward reads as the 0xFFFF end marker
`timescale 1ns/1ps
`default_nettype none

`include "camConfig_config.svh"

module cameraConfigRom
  (
    input  wire logic                   clk,
    input  wire logic [`CAM_ROM_AW-1:0] romIndex,
    output logic      [15:0]            romWord
  );

  // High byte is the register address, low byte the value
  // Data appears one clk after the index
  always_ff @(posedge clk)
  begin
    case (romIndex)
      // COM7 soft reset, then RGB output select
      6'h00: romWord <= 16'h1280;
      6'h01: romWord <= 16'h1204;
      // Output drive, full range RGB444
      6'h02: romWord <= 16'h0901;
      6'h03: romWord <= 16'h40F0;
      6'h04: romWord <= 16'h8C02;
      // Clock prescaler off, COM6, mirror and flip
      6'h05: romWord <= 16'h1180;
      6'h06: romWord <= 16'h0F4B;
      6'h07: romWord <= 16'h1E37;
      // Gain ceiling
      6'h08: romWord <= 16'h1438;
      // Colour matrix coefficients and sign
      6'h09: romWord <= 16'h4FB3;
      6'h0A: romWord <= 16'h50B3;
      6'h0B: romWord <= 16'h5100;
      6'h0C: romWord <= 16'h523D;
      6'h0D: romWord <= 16'h53A7;
      6'h0E: romWord <= 16'h54E4;
      6'h0F: romWord <= 16'h589E;
      // Gamma and UV auto adjust
      6'h10: romWord <= 16'h3DC0;
      // Reserved analog and ADC tuning
      6'h11: romWord <= 16'hB084;
      6'h12: romWord <= 16'h0E61;
      6'h13: romWord <= 16'h1602;
      6'h14: romWord <= 16'h2102;
      6'h15: romWord <= 16'h2291;
      6'h16: romWord <= 16'h2907;
      // CHLF is written twice on purpose
      6'h17: romWord <= 16'h330B;
      6'h18: romWord <= 16'h330B;
      6'h19: romWord <= 16'h350B;
      6'h1A: romWord <= 16'h371D;
      6'h1B: romWord <= 16'h3871;
      6'h1C: romWord <= 16'h392A;
      // COM12, HREF gated by VSYNC
      6'h1D: romWord <= 16'h3C78;
      6'h1E: romWord <= 16'h4D40;
      6'h1F: romWord <= 16'h4E20;
      // Digital gain bypass
      6'h20: romWord <= 16'h7410;
      6'h21: romWord <= 16'h8D4F;
      6'h22: romWord <= 16'h8E00;
      6'h23: romWord <= 16'h8F00;
      6'h24: romWord <= 16'h9000;
      6'h25: romWord <= 16'h9100;
      6'h26: romWord <= 16'h9600;
      6'h27: romWord <= 16'h9A00;
      // ABLC enable and black level target
      6'h28: romWord <= 16'hB10C;
      6'h29: romWord <= 16'hB20E;
      6'h2A: romWord <= 16'hB382;
      6'h2B: romWord <= 16'hB80A;
      // HREF instead of HSYNC, PCLK quiet in blanking
      6'h2C: romWord <= 16'h1520;
      // Window start and stop
      6'h2D: romWord <= 16'h1711;
      6'h2E: romWord <= 16'h1800;
      6'h2F: romWord <= 16'h1900;
      6'h30: romWord <= 16'h1A00;
      6'h31: romWord <= 16'h3200;
      // QVGA scaling and PCLK divider
      6'h32: romWord <= 16'h0C04;
      6'h33: romWord <= 16'h3E19;
      6'h34: romWord <= 16'h703A;
      6'h35: romWord <= 16'h7135;
      6'h36: romWord <= 16'h7211;
      6'h37: romWord <= 16'h73F1;
      6'h38: romWord <= 16'hA202;
      // End of table
      default: romWord <= 16'hFFFF;
    endcase
  end

endmodule

`default_nettype wire

//--- configInput.hex
// First line: number of register writes, then one write per line
// Each word: register address in the high byte, value in the low byte
0039
1280
1204
0901
40F0
8C02
1180
0F4B
1E37
1438
4FB3
50B3
5100
523D
53A7
54E4
589E
3DC0
B084
0E61
1602
2102
2291
2907
330B
330B
350B
371D
3871
392A
3C78
4D40
4E20
7410
8D4F
8E00
8F00
9000
9100
9600
9A00
B10C
B20E
B382
B80A
1520
1711
1800
1900
1A00
3200
0C04
3E19
703A
7135
7211
73F1
A202

//--- configSequencer.sv
// Start is honoured only in idle or done; the finish entry waits for the writer to go idle first
`timescale 1ns/1ps
`default_nettype none

`include "camConfig_config.svh"

module configSequencer
  (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   start,
    output logic                        startReady,
    output logic      [`CAM_ROM_AW-1:0] romIndex,
    input  wire logic [15:0]            romWord,
    output camConfigPkg::sccbCmd        cmd,
    output logic                        cmdValid,
    input  wire logic                   cmdReady,
    input  wire logic                   writeDone,
    output logic                        runStart,
    output logic                        finished
  );

  import camConfigPkg::*;

  localparam int WaitW = $clog2(`CAM_RESET_WAIT);

  seqState          state;
  cmdKind           entryKind;
  logic             waitArmed;
  logic [WaitW-1:0] waitCnt;

  assign startReady = (state == seqIdle) || (state == seqDone);

  // Entry classification from the ROM word
  always_comb
  begin
    if (romWord == 16'hFFFF)
      entryKind = cmdFinish;
    else if ((romWord[15:8] == 8'h12) && romWord[7])
      entryKind = cmdWriteWait;
    else
      entryKind = cmdWrite;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= seqIdle;
      romIndex  <= '0;
      cmdValid  <= 1'b0;
      runStart  <= 1'b0;
      finished  <= 1'b0;
      waitArmed <= 1'b0;
      waitCnt   <= '0;
    end
    else
    begin
      runStart <= 1'b0;
      finished <= 1'b0;
      case (state)
        seqIdle, seqDone:
          if (start)
          begin
            romIndex <= '0;
            runStart <= 1'b1;
            state    <= seqFetch;
          end
        // Index is stable here, ROM word lands at the end of this cycle
        seqFetch:
          state <= seqDecode;
        seqDecode:
          if (entryKind == cmdFinish)
          begin
            // Writer idle means the last stop and gap are over
            if (cmdReady)
            begin
              finished <= 1'b1;
              state    <= seqDone;
            end
          end
          else
          begin
            cmdValid <= 1'b1;
            state    <= seqIssue;
          end
        // Command and index held until the writer takes it
        seqIssue:
          if (cmdReady)
          begin
            cmdValid <= 1'b0;
            romIndex <= romIndex + 1'b1;
            state    <= cmd.waitAfter ? seqWait : seqFetch;
          end
        seqWait:
          if (!waitArmed)
          begin
            // Count starts at the end of the soft-reset write
            if (writeDone)
            begin
              waitArmed <= 1'b1;
              waitCnt   <= WaitW'(`CAM_RESET_WAIT - 1);
            end
          end
          else if (waitCnt == WaitW'(1))
          begin
            waitArmed <= 1'b0;
            state     <= seqFetch;
          end
          else
            waitCnt <= waitCnt - 1'b1;
        default:
          state <= seqIdle;
      endcase
    end
  end

  // Payload captured once per entry
  always_ff @(posedge clk)
  begin
    if (state == seqDecode)
    begin
      cmd.addr      <= romWord[15:8];
      cmd.value     <= romWord[7:0];
      cmd.waitAfter <= (entryKind == cmdWriteWait);
    end
  end

endmodule

`default_nettype wire

//--- configStatus.sv
// writeCount is cleared only by a new run and wraps past 63 writes
`timescale 1ns/1ps
`default_nettype none

module configStatus
  (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              runStart,
    input  wire logic              finished,
    input  wire logic              writeDone,
    output camConfigPkg::cfgStatus status
  );

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      status.busy       <= 1'b0;
      status.done       <= 1'b0;
      status.writeCount <= '0;
    end
    else if (runStart)
    begin
      // New run drops the previous result
      status.busy       <= 1'b1;
      status.done       <= 1'b0;
      status.writeCount <= '0;
    end
    else
    begin
      if (writeDone)
        status.writeCount <= status.writeCount + 1'b1;
      // Done holds until the next start
      if (finished)
      begin
        status.busy <= 1'b0;
        status.done <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- sccbWriter.sv
// Write cycles only; the ninth bit of each frame is released and never checked for an acknowledge
`timescale 1ns/1ps
`default_nettype none

`include "camConfig_config.svh"

module sccbWriter
  (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire camConfigPkg::sccbCmd cmd,
    input  wire logic                 cmdValid,
    output logic                      cmdReady,
    output logic                      writeDone,
    output logic                      sioc,
    output logic                      siodOut,
    output logic                      siodOe
  );

  import camConfigPkg::*;

  localparam int Quarter = `CAM_SCCB_QUARTER;
  localparam int TickW   = (Quarter > 1) ? $clog2(Quarter) : 1;
  // Zero marks the released ninth bit of each 9-bit frame
  localparam logic [26:0] DriveMask = 27'b111111110_111111110_111111110;

  sccbPhase         phase;
  logic [TickW-1:0] tickCnt;
  logic [1:0]       quarter;
  logic [4:0]       bitCnt;
  logic [26:0]      shiftData;
  logic             quarterEnd;
  logic             bitEnd;
  logic             accept;

  assign cmdReady   = (phase == phIdle);
  assign accept     = cmdReady && cmdValid;
  assign quarterEnd = (tickCnt == TickW'(Quarter - 1));
  assign bitEnd     = quarterEnd && (quarter == 2'd3);
  // Last cycle of the stop condition
  assign writeDone  = (phase == phStop) && bitEnd;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      phase   <= phIdle;
      tickCnt <= '0;
      quarter <= 2'd0;
      bitCnt  <= 5'd0;
    end
    else if (phase == phIdle)
    begin
      tickCnt <= '0;
      quarter <= 2'd0;
      if (accept)
        phase <= phStart;
    end
    else
    begin
      // Every active phase lasts a whole number of bit periods
      if (quarterEnd)
      begin
        tickCnt <= '0;
        quarter <= quarter + 1'b1;
      end
      else
        tickCnt <= tickCnt + 1'b1;
      if (bitEnd)
      begin
        case (phase)
          phStart:
          begin
            bitCnt <= 5'd0;
            phase  <= phShift;
          end
          phShift:
            if (bitCnt == 5'd26)
              phase <= phStop;
            else
              bitCnt <= bitCnt + 1'b1;
          phStop:
            phase <= phGap;
          default:
            phase <= phIdle;
        endcase
      end
    end
  end

  // Device ID, register address and value frames each end in a released ninth bit
  always_ff @(posedge clk)
  begin
    if (accept)
      shiftData <= {`CAM_SCCB_ID, 1'b1, cmd.addr, 1'b1, cmd.value, 1'b1};
    else if ((phase == phShift) && bitEnd)
      shiftData <= {shiftData[25:0], 1'b1};
  end

  // Pin levels decoded from flops
  // Data moves in quarter 0 while SIOC is low
  always_comb
  begin
    sioc    = 1'b1;
    siodOut = 1'b1;
    siodOe  = 1'b1;
    case (phase)
      // SIOD falls with SIOC high, then SIOC drops
      phStart:
      begin
        siodOut = (quarter == 2'd0);
        sioc    = (quarter != 2'd3);
      end
      phShift:
      begin
        sioc    = (quarter == 2'd1) || (quarter == 2'd2);
        siodOut = shiftData[26];
        siodOe  = DriveMask[5'd26 - bitCnt];
      end
      // SIOC rises first, SIOD follows while SIOC is high
      phStop:
      begin
        sioc    = (quarter != 2'd0);
        siodOut = (quarter >= 2'd2);
      end
      default:
      begin
        sioc    = 1'b1;
        siodOut = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire
